// File: rtl/sched_pkg.sv
package sched_pkg;

    // bank organisation
    localparam int NUM_GROUPS      = 2;
    localparam int BANKS_PER_GROUP = 4;
    localparam int NUM_BANKS       = NUM_GROUPS * BANKS_PER_GROUP;
    localparam int BANK_BITS       = $clog2(NUM_BANKS);   // {group, bank} as one index

    // address fields
    localparam int ROW_BITS        = 8;
    localparam int COL_BITS        = 4;
    localparam int REQ_ADDR_BITS   = BANK_BITS + ROW_BITS + COL_BITS;  // group, bank, row, col
    localparam int CMD_ADDR_BITS   = 11;

    localparam int DATA_BITS       = 32;
    localparam int QUEUE_DEPTH     = 4;    // entries per bank, equal to the credits per bank

    // bank timing in clock cycles
    localparam int ACT_LATENCY     = 8;    // activate to read or write
    localparam int PRE_LATENCY     = 5;    // precharge to activate

    // one queued request, the bank is implied by the queue holding it
    typedef struct packed {
        logic [ROW_BITS-1:0]  row;
        logic [COL_BITS-1:0]  col;
        logic                 write;
        logic [DATA_BITS-1:0] data;
    } bank_req_t;

    typedef enum logic [1:0] {
        CMD_READ      = 2'd0,
        CMD_WRITE     = 2'd1,
        CMD_ACTIVATE  = 2'd2,
        CMD_PRECHARGE = 2'd3
    } dram_cmd_e;

    // activate carries the row
    typedef struct packed {
        logic [BANK_BITS-1:0] bank;
        logic [ROW_BITS-1:0]  row;
    } row_view_t;

    // read, write and precharge carry the column
    typedef struct packed {
        logic [BANK_BITS-1:0]                        bank;
        logic [CMD_ADDR_BITS-BANK_BITS-COL_BITS-1:0] zero;
        logic [COL_BITS-1:0]                         col;
    } col_view_t;

    // bank index sits in the top bits of both views
    typedef union packed {
        row_view_t row_v;
        col_view_t col_v;
    } cmd_addr_u;

    typedef struct packed {
        logic                 valid;
        dram_cmd_e            cmd;
        cmd_addr_u            addr;
        logic [DATA_BITS-1:0] data;   // zero unless write
    } dram_cmd_t;

    typedef struct packed {
        logic                 valid;
        logic [BANK_BITS-1:0] bank;
    } credit_t;

endpackage

// File: rtl/req_intake.sv
`timescale 1ns/10ps

module req_intake
    import sched_pkg::*;
(
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic                     req_valid,
    input  logic [REQ_ADDR_BITS-1:0] req_addr,
    input  logic                     req_write,
    input  logic [DATA_BITS-1:0]     req_data,
    output logic [NUM_BANKS-1:0]     push,
    output bank_req_t                push_req
);

    logic [BANK_BITS-1:0] bank_idx;
    bank_req_t            req_split;

    // address split, bank group and bank together form the flat index
    always_comb begin
        bank_idx        = req_addr[REQ_ADDR_BITS-1 -: BANK_BITS];
        req_split.row   = req_addr[COL_BITS +: ROW_BITS];
        req_split.col   = req_addr[COL_BITS-1:0];
        req_split.write = req_write;
        req_split.data  = req_data;
    end

    // one-hot steering toward the bank queue
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            push <= '0;
        end else begin
            push <= '0;
            if (req_valid) begin
                push[bank_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (req_valid) begin
            push_req <= req_split;  // payload only
        end
    end

endmodule

// File: rtl/bank_queue.sv
`timescale 1ns/10ps

module bank_queue
    import sched_pkg::*;
(
    input  logic      clk_in,
    input  logic      rst_in,
    input  logic      push,
    input  bank_req_t push_req,
    input  logic      pop,
    output bank_req_t head,
    output logic      head_valid
);

    typedef logic [$clog2(QUEUE_DEPTH)-1:0] ptr_t;

    bank_req_t                        mem [QUEUE_DEPTH];
    ptr_t                             wr_ptr;
    ptr_t                             rd_ptr;
    logic [$clog2(QUEUE_DEPTH+1)-1:0] count;

    // wrap explicitly so a depth that is not a power of two also works
    function automatic ptr_t next_ptr(input ptr_t p);
        if (p == ptr_t'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign head       = mem[rd_ptr];
    assign head_valid = (count != '0);

    always_ff @(posedge clk_in) begin
        if (push) begin
            mem[wr_ptr] <= push_req;
        end
    end

    // credits upstream keep push from ever hitting a full queue
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;         // idle or push and pop together
            endcase
        end
    end

endmodule

// File: rtl/bank_tracker.sv
`timescale 1ns/10ps

module bank_tracker
    import sched_pkg::*;
(
    input  logic                               clk_in,
    input  logic                               rst_in,
    input  dram_cmd_t                          issue,
    output logic [NUM_BANKS-1:0][ROW_BITS-1:0] open_row,
    output logic [NUM_BANKS-1:0]               bank_open,
    output logic [NUM_BANKS-1:0]               bank_busy
);

    typedef logic [$clog2(ACT_LATENCY)-1:0] timer_t;

    timer_t               timer [NUM_BANKS];
    logic [NUM_BANKS-1:0] act_pend;     // activate in flight, opens when the timer expires
    logic [BANK_BITS-1:0] issue_bank;
    logic                 issue_act;
    logic                 issue_pre;

    // both union views hold the bank in the same bits
    assign issue_bank = issue.addr.row_v.bank;
    assign issue_act  = issue.valid && (issue.cmd == CMD_ACTIVATE);
    assign issue_pre  = issue.valid && (issue.cmd == CMD_PRECHARGE);

    // the issue cycle itself already blocks the bank, the timer covers the rest
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_busy[b] = (timer[b] != '0)
                           || ((issue_act || issue_pre) && (issue_bank == BANK_BITS'(b)));
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            bank_open <= '0;
            act_pend  <= '0;
            for (int b = 0; b < NUM_BANKS; b++) begin
                timer[b] <= '0;
            end
        end else begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (timer[b] != '0) begin
                    timer[b] <= timer[b] - 1'b1;
                    if (timer[b] == timer_t'(1) && act_pend[b]) begin
                        bank_open[b] <= 1'b1;   // row now usable
                        act_pend[b]  <= 1'b0;
                    end
                end
            end
            if (issue_act) begin
                timer[issue_bank]    <= timer_t'(ACT_LATENCY - 1);
                act_pend[issue_bank] <= 1'b1;
            end else if (issue_pre) begin
                timer[issue_bank]     <= timer_t'(PRE_LATENCY - 1);
                bank_open[issue_bank] <= 1'b0;
            end
        end
    end

    // row value only matters while bank_open is set
    always_ff @(posedge clk_in) begin
        if (issue_act) begin
            open_row[issue_bank] <= issue.addr.row_v.row;
        end
    end

endmodule

// File: rtl/cmd_arbiter.sv
`timescale 1ns/10ps

module cmd_arbiter
    import sched_pkg::*;
(
    input  logic                               clk_in,
    input  logic                               rst_in,
    input  logic                               cmd_ready,
    input  bank_req_t [NUM_BANKS-1:0]          head,
    input  logic [NUM_BANKS-1:0]               head_valid,
    input  logic [NUM_BANKS-1:0][ROW_BITS-1:0] open_row,
    input  logic [NUM_BANKS-1:0]               bank_open,
    input  logic [NUM_BANKS-1:0]               bank_busy,
    output logic [NUM_BANKS-1:0]               pop,
    output dram_cmd_t                          cmd_out,
    output credit_t                            credit_out
);

    logic [NUM_BANKS-1:0] hit;
    logic [NUM_BANKS-1:0] need_act;
    logic [NUM_BANKS-1:0] need_pre;
    logic                 sel_valid;
    logic [BANK_BITS-1:0] sel_bank;
    dram_cmd_e            sel_cmd;
    bank_req_t            sel_req;
    logic                 sel_access;
    dram_cmd_t            cmd_next;

    // classify each bank head that may be served now
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            hit[b]      = head_valid[b] && !bank_busy[b] && bank_open[b]
                          && (open_row[b] == head[b].row);
            need_act[b] = head_valid[b] && !bank_busy[b] && !bank_open[b];
            need_pre[b] = head_valid[b] && !bank_busy[b] && bank_open[b]
                          && (open_row[b] != head[b].row);
        end
    end

    // later loops override earlier ones, descending index so the lowest bank wins
    always_comb begin
        sel_valid = 1'b0;
        sel_bank  = '0;
        sel_cmd   = CMD_READ;
        for (int b = NUM_BANKS - 1; b >= 0; b--) begin
            if (need_pre[b]) begin
                sel_valid = 1'b1;
                sel_bank  = BANK_BITS'(b);
                sel_cmd   = CMD_PRECHARGE;
            end
        end
        for (int b = NUM_BANKS - 1; b >= 0; b--) begin
            if (need_act[b]) begin
                sel_valid = 1'b1;
                sel_bank  = BANK_BITS'(b);
                sel_cmd   = CMD_ACTIVATE;
            end
        end
        for (int b = NUM_BANKS - 1; b >= 0; b--) begin
            if (hit[b]) begin
                sel_valid = 1'b1;
                sel_bank  = BANK_BITS'(b);
                sel_cmd   = head[b].write ? CMD_WRITE : CMD_READ;
            end
        end
    end

    assign sel_req    = head[sel_bank];
    assign sel_access = (sel_cmd == CMD_READ) || (sel_cmd == CMD_WRITE);

    // only a column access consumes the queue entry
    always_comb begin
        pop = '0;
        if (cmd_ready && sel_valid && sel_access) begin
            pop[sel_bank] = 1'b1;
        end
    end

    always_comb begin
        cmd_next.valid = cmd_ready && sel_valid;
        cmd_next.cmd   = sel_cmd;
        if (sel_cmd == CMD_ACTIVATE) begin
            cmd_next.addr.row_v.bank = sel_bank;
            cmd_next.addr.row_v.row  = sel_req.row;
        end else begin
            cmd_next.addr.col_v.bank = sel_bank;
            cmd_next.addr.col_v.zero = '0;
            cmd_next.addr.col_v.col  = sel_req.col;
        end
        cmd_next.data = (sel_cmd == CMD_WRITE) ? sel_req.data : '0;
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            cmd_out    <= '0;
            credit_out <= '0;
        end else begin
            cmd_out          <= cmd_next;
            credit_out.valid <= cmd_ready && sel_valid && sel_access;  // same edge as the pop
            credit_out.bank  <= sel_bank;
        end
    end

endmodule

// File: rtl/dram_scheduler.sv
`timescale 1ns/10ps

module dram_scheduler
    import sched_pkg::*;
(
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic                     req_valid,
    input  logic [REQ_ADDR_BITS-1:0] req_addr,
    input  logic                     req_write,
    input  logic [DATA_BITS-1:0]     req_data,
    input  logic                     cmd_ready,
    output dram_cmd_t                cmd_out,
    output credit_t                  credit_out
);

    logic [NUM_BANKS-1:0]               push;
    bank_req_t                          push_req;
    logic [NUM_BANKS-1:0]               pop;
    bank_req_t [NUM_BANKS-1:0]          head;
    logic [NUM_BANKS-1:0]               head_valid;
    logic [NUM_BANKS-1:0][ROW_BITS-1:0] open_row;
    logic [NUM_BANKS-1:0]               bank_open;
    logic [NUM_BANKS-1:0]               bank_busy;

    req_intake i_intake (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .req_valid(req_valid),
        .req_addr (req_addr),
        .req_write(req_write),
        .req_data (req_data),
        .push     (push),
        .push_req (push_req)
    );

    // one queue per bank, all share the registered request
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_queue
        bank_queue i_queue (
            .clk_in    (clk_in),
            .rst_in    (rst_in),
            .push      (push[b]),
            .push_req  (push_req),
            .pop       (pop[b]),
            .head      (head[b]),
            .head_valid(head_valid[b])
        );
    end

    bank_tracker i_tracker (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .issue    (cmd_out),      // registered command feeds back
        .open_row (open_row),
        .bank_open(bank_open),
        .bank_busy(bank_busy)
    );

    cmd_arbiter i_arbiter (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .cmd_ready (cmd_ready),
        .head      (head),
        .head_valid(head_valid),
        .open_row  (open_row),
        .bank_open (bank_open),
        .bank_busy (bank_busy),
        .pop       (pop),
        .cmd_out   (cmd_out),
        .credit_out(credit_out)
    );

endmodule

// File: test/dram_scheduler_sva.sv
`timescale 1ns/10ps

module dram_scheduler_sva
    import sched_pkg::*;
(
    input logic      clk_in,
    input logic      rst_in,
    input logic      cmd_ready,
    input dram_cmd_t cmd_out,
    input credit_t   credit_out
);

    logic [4:0]           since_act [NUM_BANKS];  // cycles since the last activate, saturating
    logic [4:0]           since_pre [NUM_BANKS];
    logic [BANK_BITS-1:0] cmd_bank;
    logic                 is_access;
    logic                 is_act;
    logic                 is_pre;

    assign cmd_bank  = cmd_out.addr.row_v.bank;  // same bits in the column view
    assign is_access = cmd_out.valid && (cmd_out.cmd == CMD_READ || cmd_out.cmd == CMD_WRITE);
    assign is_act    = cmd_out.valid && (cmd_out.cmd == CMD_ACTIVATE);
    assign is_pre    = cmd_out.valid && (cmd_out.cmd == CMD_PRECHARGE);

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                since_act[b] <= '1;
                since_pre[b] <= '1;
            end
        end else begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (is_act && cmd_bank == BANK_BITS'(b)) begin
                    since_act[b] <= 5'd1;
                end else if (since_act[b] != '1) begin
                    since_act[b] <= since_act[b] + 5'd1;
                end
                if (is_pre && cmd_bank == BANK_BITS'(b)) begin
                    since_pre[b] <= 5'd1;
                end else if (since_pre[b] != '1) begin
                    since_pre[b] <= since_pre[b] + 5'd1;
                end
            end
        end
    end

    a_ready: assert property (@(posedge clk_in) disable iff (rst_in)
        !cmd_ready |=> !cmd_out.valid)
        else $error("command issued after a cycle without cmd_ready");

    a_act_to_access: assert property (@(posedge clk_in) disable iff (rst_in)
        is_access |-> since_act[cmd_bank] >= ACT_LATENCY)
        else $error("read or write too soon after activate");

    a_pre_to_act: assert property (@(posedge clk_in) disable iff (rst_in)
        is_act |-> since_pre[cmd_bank] >= PRE_LATENCY)
        else $error("activate too soon after precharge");

    a_credit: assert property (@(posedge clk_in) disable iff (rst_in)
        (credit_out.valid == is_access) && (!is_access || credit_out.bank == cmd_bank))
        else $error("credit return does not match the column command");

endmodule

bind dram_scheduler dram_scheduler_sva i_sva (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .cmd_ready (cmd_ready),
    .cmd_out   (cmd_out),
    .credit_out(credit_out)
);

// File: test/tb_dram_scheduler.sv
`timescale 1ns/10ps

module tb_dram_scheduler
    import sched_pkg::*;
();

    typedef struct packed {
        logic                grp;
        logic [1:0]          bank;
        logic [ROW_BITS-1:0] row;
        logic [COL_BITS-1:0] col;
        logic                write;
        logic [3:0]          gap;    // idle cycles before the request
    } stim_t;

    typedef struct packed {
        logic [BANK_BITS-1:0]     bank;
        dram_cmd_e                cmd;
        logic [CMD_ADDR_BITS-1:0] addr;
        logic [DATA_BITS-1:0]     data;
    } exp_t;

    localparam int NUM_STIM        = 16;
    localparam int STALL_ROW       = 8;   // cmd_ready held low after this row
    localparam int STALL_CYCLES    = 20;
    localparam int WATCHDOG_CYCLES = 10 + STALL_CYCLES + NUM_STIM * 60 + 200;

    // group, bank, row, column, write, gap
    localparam stim_t STIM [NUM_STIM] = '{
        '{1'b0, 2'd0, 8'h12, 4'h3, 1'b0, 4'd2},
        '{1'b0, 2'd0, 8'h12, 4'h5, 1'b1, 4'd0},   // row hit
        '{1'b0, 2'd0, 8'h34, 4'h1, 1'b0, 4'd0},   // row miss
        '{1'b1, 2'd1, 8'ha5, 4'hf, 1'b1, 4'd1},
        '{1'b0, 2'd2, 8'h07, 4'h2, 1'b0, 4'd0},
        '{1'b0, 2'd2, 8'h07, 4'h4, 1'b1, 4'd0},
        '{1'b0, 2'd2, 8'h08, 4'h6, 1'b0, 4'd0},
        '{1'b0, 2'd2, 8'h07, 4'h8, 1'b1, 4'd0},
        '{1'b0, 2'd2, 8'h09, 4'ha, 1'b0, 4'd0},   // fifth request to one bank waits for a credit
        '{1'b1, 2'd3, 8'hff, 4'h0, 1'b0, 4'd3},
        '{1'b1, 2'd0, 8'h40, 4'hc, 1'b1, 4'd0},
        '{1'b0, 2'd0, 8'h34, 4'h7, 1'b1, 4'd0},
        '{1'b1, 2'd3, 8'hfe, 4'h1, 1'b0, 4'd2},
        '{1'b0, 2'd1, 8'h66, 4'h9, 1'b1, 4'd0},
        '{1'b1, 2'd2, 8'h10, 4'hd, 1'b0, 4'd1},
        '{1'b0, 2'd0, 8'h12, 4'he, 1'b0, 4'd0}
    };

    logic                     clk_in;
    logic                     rst_in;
    logic                     req_valid;
    logic [REQ_ADDR_BITS-1:0] req_addr;
    logic                     req_write;
    logic [DATA_BITS-1:0]     req_data;
    logic                     cmd_ready;
    dram_cmd_t                cmd_out;
    credit_t                  credit_out;

    logic [31:0]          rng_state;
    logic                 hold_ready_low;
    logic                 ready_q;                // cmd_ready as seen at the last edge
    int                   credits [NUM_BANKS];
    logic                 model_open [NUM_BANKS];
    logic [ROW_BITS-1:0]  model_row [NUM_BANKS];
    exp_t                 exp_q [$];

    dram_scheduler i_dut (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .req_valid (req_valid),
        .req_addr  (req_addr),
        .req_write (req_write),
        .req_data  (req_data),
        .cmd_ready (cmd_ready),
        .cmd_out   (cmd_out),
        .credit_out(credit_out)
    );

    always #5 clk_in = ~clk_in;

    always @(posedge clk_in) ready_q <= cmd_ready;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic bit credits_full();
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (credits[b] != QUEUE_DEPTH) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s at %0t ns", reason, $time);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_values(input string name, input logic [63:0] expected,
                                  input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %0h actual %0h", name, expected, actual);
            abort_run("stopping at the first mismatch");
        end
    endtask

    // every input change happens here on the falling edge
    task automatic next_cycle();
        @(negedge clk_in);
        rng_state = xorshift32(rng_state);
        cmd_ready = hold_ready_low ? 1'b0 : (rng_state[1:0] != 2'b00);
        req_valid = 1'b0;
    endtask

    task automatic expect_cmd(input logic [BANK_BITS-1:0] bank, input dram_cmd_e cmd,
                              input logic [CMD_ADDR_BITS-1:0] addr,
                              input logic [DATA_BITS-1:0] data);
        exp_t e;
        e.bank = bank;
        e.cmd  = cmd;
        e.addr = addr;
        e.data = data;
        exp_q.push_back(e);
    endtask

    // per bank open row model appending commands in table order
    task automatic model_request(input stim_t s, input logic [DATA_BITS-1:0] data);
        logic [BANK_BITS-1:0]     bank;
        logic [CMD_ADDR_BITS-1:0] col_addr;
        bank     = {s.grp, s.bank};
        col_addr = {bank, 4'b0000, s.col};
        if (model_open[bank] && model_row[bank] != s.row) begin
            expect_cmd(bank, CMD_PRECHARGE, col_addr, '0);
            model_open[bank] = 1'b0;
        end
        if (!model_open[bank]) begin
            expect_cmd(bank, CMD_ACTIVATE, {bank, s.row}, '0);
            model_open[bank] = 1'b1;
            model_row[bank]  = s.row;
        end
        expect_cmd(bank, s.write ? CMD_WRITE : CMD_READ, col_addr, s.write ? data : '0);
    endtask

    task automatic send_request(input stim_t s);
        logic [BANK_BITS-1:0] bank;
        bank = {s.grp, s.bank};
        next_cycle();
        req_valid     = 1'b1;
        req_addr      = {bank, s.row, s.col};
        req_write     = s.write;
        req_data      = rng_state;              // reads must not pass this through
        credits[bank] = credits[bank] - 1;
        model_request(s, rng_state);
    endtask

    task automatic stall_ready();
        hold_ready_low = 1'b1;
        for (int c = 0; c < STALL_CYCLES; c++) begin
            next_cycle();
            if (c > 0) begin
                compare_values("stall_cmd_valid", 0, cmd_out.valid);
            end
        end
        hold_ready_low = 1'b0;
    endtask

    task automatic check_outputs();
        logic [CMD_ADDR_BITS-1:0] addr;
        logic [BANK_BITS-1:0]     bank;
        int                       idx;
        exp_t                     e;
        addr = cmd_out.addr;
        bank = addr[CMD_ADDR_BITS-1 -: BANK_BITS];
        if (!cmd_out.valid) begin
            compare_values("credit_without_cmd", 0, credit_out.valid);
            return;
        end
        if (!ready_q) begin
            abort_run("a command was issued while cmd_ready was low");
        end
        idx = -1;
        for (int k = exp_q.size() - 1; k >= 0; k--) begin
            if (exp_q[k].bank == bank) begin
                idx = k;   // oldest entry of this bank
            end
        end
        if (idx < 0) begin
            abort_run("a command arrived for a bank with nothing expected");
        end
        e = exp_q[idx];
        exp_q.delete(idx);
        compare_values("cmd_type", e.cmd, cmd_out.cmd);
        compare_values("cmd_addr", e.addr, addr);
        compare_values("cmd_data", e.data, cmd_out.data);
        compare_values("credit_valid", (e.cmd == CMD_READ) || (e.cmd == CMD_WRITE),
                       credit_out.valid);
        if (credit_out.valid) begin
            compare_values("credit_bank", e.bank, credit_out.bank);
            credits[e.bank] = credits[e.bank] + 1;
        end
    endtask

    always @(negedge clk_in) begin
        if (!rst_in) begin
            check_outputs();
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        abort_run("watchdog expired before all commands were seen");
    end

    initial begin
        clk_in         = 1'b0;
        rst_in         = 1'b1;
        req_valid      = 1'b0;
        req_addr       = '0;
        req_write      = 1'b0;
        req_data       = '0;
        cmd_ready      = 1'b0;
        ready_q        = 1'b0;
        hold_ready_low = 1'b0;
        rng_state      = 32'd42605;
        for (int b = 0; b < NUM_BANKS; b++) begin
            credits[b]    = QUEUE_DEPTH;
            model_open[b] = 1'b0;
            model_row[b]  = '0;
        end
        repeat (10) @(negedge clk_in);
        rst_in = 1'b0;

        // quiet outputs before any request
        repeat (5) begin
            next_cycle();
            compare_values("idle_cmd_valid", 0, cmd_out.valid);
            compare_values("idle_credit_valid", 0, credit_out.valid);
        end

        for (int i = 0; i < NUM_STIM; i++) begin
            repeat (STIM[i].gap) next_cycle();
            while (credits[{STIM[i].grp, STIM[i].bank}] == 0) begin
                next_cycle();
            end
            send_request(STIM[i]);
            if (i == STALL_ROW) begin
                stall_ready();
            end
        end

        while (exp_q.size() != 0) begin
            next_cycle();
        end
        repeat (5) next_cycle();
        if (credits_full()) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            abort_run("not every credit came back after the last command");
        end
    end

endmodule

// File: build.f
rtl/sched_pkg.sv
rtl/req_intake.sv
rtl/bank_queue.sv
rtl/bank_tracker.sv
rtl/cmd_arbiter.sv
rtl/dram_scheduler.sv
test/dram_scheduler_sva.sv
test/tb_dram_scheduler.sv

// File: Makefile
TOP := tb_dram_scheduler
LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f -o sim
	./obj_dir/sim | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "Simulation finished: PASS" $(LOG) || { echo "no pass line in log"; exit 1; }

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir $(LOG)
